// File: hdl/l0_cache_pkg.sv
// -------------------------------------------------------------------------
// Shared geometry, opcodes and types of the level-0 instruction cache.
// The geometry is fixed. Lines must hold a whole number of 32-bit words.
// -------------------------------------------------------------------------

package l0_cache_pkg;

  // Geometry
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned FetchWidth   = 32;
  localparam int unsigned LineWidth    = 128;
  localparam int unsigned LineCount    = 4;
  localparam int unsigned LineAlign    = 4;
  localparam int unsigned FetchAlign   = 2;
  localparam int unsigned WordsPerLine = LineWidth / FetchWidth;
  localparam int unsigned TagWidth     = AddrWidth - LineAlign;

  // RISC-V major opcodes seen by the predecoder
  localparam logic [6:0] OpcBranch = 7'b1100011;
  localparam logic [6:0] OpcJal    = 7'b1101111;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [LineWidth-1:0] line_t;
  typedef logic [TagWidth-1:0]  tag_t;
  typedef logic [LineCount-1:0] line_sel_t;

  // One instruction word, read either as a conditional branch or as a JAL
  typedef union packed {
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_t;

endpackage

// File: hdl/l0_line_store.sv
// -------------------------------------------------------------------------
// Tag, valid and data registers of the fully associative line array.
// Evict wins over validate on the same line. Flush clears every valid bit.
// Hits are combinational from both addresses.
// -------------------------------------------------------------------------

module l0_line_store import l0_cache_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addr_t                 fetch_addr_i,
  input  addr_t                 prefetch_addr_i,
  input  line_sel_t             evict_i,
  input  logic                  evict_prefetch_i,
  input  line_sel_t             validate_i,
  input  logic                  flush_i,
  input  line_t                 rsp_data_i,
  output line_sel_t             hit_line_o,
  output logic                  fetch_hit_o,
  output logic                  prefetch_hit_o,
  output line_t                 line_data_o,
  output logic [FetchWidth-1:0] fetch_data_o
);

  tag_t      fetch_tag;
  tag_t      prefetch_tag;
  tag_t      tag_q [LineCount];
  line_t     data_q [LineCount];
  line_sel_t valid_q;
  line_sel_t valid_d;
  line_sel_t fetch_hit;
  line_sel_t prefetch_hit;

  logic [WordsPerLine-1:0][FetchWidth-1:0] line_words;

  assign fetch_tag    = fetch_addr_i[AddrWidth-1:LineAlign];
  assign prefetch_tag = prefetch_addr_i[AddrWidth-1:LineAlign];

  // -------------------------------------------------------------------------
  // Storage
  // -------------------------------------------------------------------------
  always_comb begin
    valid_d = valid_q;
    for (int i = 0; i < LineCount; i++) begin
      if (evict_i[i]) begin
        valid_d[i] = 1'b0;
      end else if (validate_i[i]) begin
        valid_d[i] = 1'b1;
      end
    end
    if (flush_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // The evicted line takes the tag of whichever request caused the eviction
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < LineCount; i++) begin
      if (evict_i[i]) begin
        tag_q[i] <= evict_prefetch_i ? prefetch_tag : fetch_tag;
      end
      if (validate_i[i]) begin
        data_q[i] <= rsp_data_i;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Lookup
  // -------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < LineCount; i++) begin
      fetch_hit[i]    = valid_q[i] && (tag_q[i] == fetch_tag);
      prefetch_hit[i] = valid_q[i] && (tag_q[i] == prefetch_tag);
    end
  end

  assign hit_line_o     = fetch_hit;
  assign fetch_hit_o    = |fetch_hit;
  assign prefetch_hit_o = |prefetch_hit;

  // At most one line hits, so an AND-OR mux is enough
  always_comb begin
    line_data_o = '0;
    for (int i = 0; i < LineCount; i++) begin
      line_data_o |= {LineWidth{fetch_hit[i]}} & data_q[i];
    end
  end

  assign line_words   = line_data_o;
  assign fetch_data_o = line_words[fetch_addr_i[LineAlign-1:FetchAlign]];

endmodule

// File: hdl/l0_victim_select.sv
// -------------------------------------------------------------------------
// Round-robin replacement. The line being hit by the fetch is skipped.
// The offer is valid in every cycle; it only advances on a request.
// -------------------------------------------------------------------------

module l0_victim_select import l0_cache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      evict_req_i,
  input  line_sel_t hit_line_i,
  output line_sel_t victim_o
);

  logic [$clog2(LineCount)-1:0] cnt_q;
  logic [$clog2(LineCount)-1:0] cnt_d;
  line_sel_t                    first_pick;
  logic                         skip;

  assign first_pick = line_sel_t'(1) << cnt_q;
  // Never take the line the fetch is currently reading from
  assign skip       = (first_pick == hit_line_i);

  always_comb begin
    victim_o = skip ? line_sel_t'(1) << (cnt_q + 1'b1) : first_pick;
    cnt_d    = cnt_q;
    if (evict_req_i) begin
      cnt_d = skip ? cnt_q + 2'd2 : cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: hdl/l0_refill_ctrl.sv
// -------------------------------------------------------------------------
// Miss and prefetch control with a single outstanding refill.
// Responses are always accepted and carry the whole line in one beat.
// A demand refill wins the request port over a pending prefetch.
// -------------------------------------------------------------------------

module l0_refill_ctrl import l0_cache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      fetch_valid_i,
  input  logic      fetch_hit_i,
  input  logic      prefetch_hit_i,
  input  logic      enable_prefetch_i,
  input  addr_t     fetch_addr_i,
  input  addr_t     prefetch_addr_i,
  input  line_sel_t victim_i,
  input  logic      out_req_ready_i,
  input  logic      out_rsp_valid_i,
  output logic      evict_req_o,
  output line_sel_t evict_o,
  output logic      evict_prefetch_o,
  output line_sel_t validate_o,
  output addr_t     out_req_addr_o,
  output logic      out_req_prefetch_o,
  output logic      out_req_valid_o
);

  logic      miss;
  logic      miss_q;
  logic      evict_miss;
  logic      latch_prefetch;
  logic      pending_q;
  logic      pending_d;
  logic      pf_req_q;
  logic      pf_req_d;
  addr_t     pf_addr_q;
  line_sel_t refill_line_q;

  // -------------------------------------------------------------------------
  // Miss and prefetch detection
  // -------------------------------------------------------------------------
  assign miss       = fetch_valid_i && !fetch_hit_i && !pending_q;
  // Only the first cycle of a miss evicts, back-pressure must not evict again
  assign evict_miss = miss && !miss_q;

  // Sets pending right away, so this is high for one cycle at most
  assign latch_prefetch = enable_prefetch_i && fetch_valid_i && fetch_hit_i &&
                          !prefetch_hit_i && !pending_q && !pf_req_q;

  assign evict_req_o      = evict_miss || latch_prefetch;
  assign evict_prefetch_o = latch_prefetch;
  assign evict_o          = {LineCount{evict_req_o}} & victim_i;

  // -------------------------------------------------------------------------
  // Outstanding refill
  // -------------------------------------------------------------------------
  always_comb begin
    pending_d = pending_q;
    if (pending_q) begin
      if (out_rsp_valid_i) begin
        pending_d = 1'b0;
      end
    end else if ((miss && out_req_ready_i) || latch_prefetch) begin
      pending_d = 1'b1;
    end
  end

  assign validate_o = {LineCount{pending_q && out_rsp_valid_i}} & refill_line_q;

  // Prefetch request register
  always_comb begin
    pf_req_d = pf_req_q;
    if (out_req_ready_i && !miss) begin
      pf_req_d = 1'b0;
    end
    if (latch_prefetch) begin
      pf_req_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q    <= 1'b0;
      pending_q <= 1'b0;
      pf_req_q  <= 1'b0;
    end else begin
      miss_q    <= miss;
      pending_q <= pending_d;
      pf_req_q  <= pf_req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (evict_req_o) begin
      refill_line_q <= victim_i;
    end
    if (latch_prefetch) begin
      pf_addr_q <= prefetch_addr_i;
    end
  end

  // -------------------------------------------------------------------------
  // Request port
  // -------------------------------------------------------------------------
  assign out_req_valid_o    = miss || pf_req_q;
  assign out_req_prefetch_o = !miss && pf_req_q;
  assign out_req_addr_o     = miss ? {fetch_addr_i[AddrWidth-1:LineAlign], {LineAlign{1'b0}}}
                                   : pf_addr_q;

endmodule

// File: hdl/l0_branch_predecode.sv
// -------------------------------------------------------------------------
// Static prefetch target from the hit line. Backward branches count as
// taken, JAL always does. JALR is not followed.
// Only words at or after the fetched word are considered.
// -------------------------------------------------------------------------

module l0_branch_predecode import l0_cache_pkg::*; (
  input  addr_t fetch_addr_i,
  input  line_t line_i,
  output addr_t prefetch_addr_o
);

  instr_t [WordsPerLine-1:0]         words;
  logic   [WordsPerLine-1:0]         is_branch;
  logic   [WordsPerLine-1:0]         is_jal;
  logic   [WordsPerLine-1:0]         mask;
  logic   [WordsPerLine-1:0]         marked;
  logic   [LineAlign-FetchAlign-1:0] sel_idx;
  instr_t                            sel_word;
  addr_t                             b_imm;
  addr_t                             j_imm;
  addr_t                             base;
  addr_t                             offset;
  addr_t                             target;

  assign words = line_i;

  // -------------------------------------------------------------------------
  // Classify every word
  // -------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < WordsPerLine; i++) begin
      // funct3 010 and 011 are not branches
      is_branch[i] = (words[i].b.opcode == OpcBranch) &&
                     (words[i].b.funct3[2:1] != 2'b01) &&
                     words[i].b.imm12;
      is_jal[i]    = (words[i].j.opcode == OpcJal);
    end
  end

  assign mask   = {WordsPerLine{1'b1}} << fetch_addr_i[LineAlign-1:FetchAlign];
  assign marked = mask & (is_branch | is_jal);

  // First marked word, lowest index wins
  always_comb begin
    sel_idx = '0;
    for (int i = WordsPerLine - 1; i >= 0; i--) begin
      if (marked[i]) begin
        sel_idx = (LineAlign-FetchAlign)'(i);
      end
    end
  end

  assign sel_word = words[sel_idx];

  // Sign-extended B and J immediates
  assign b_imm = {{(AddrWidth-12){sel_word.b.imm12}}, sel_word.b.imm11,
                  sel_word.b.imm10_5, sel_word.b.imm4_1, 1'b0};
  assign j_imm = {{(AddrWidth-20){sel_word.j.imm20}}, sel_word.j.imm19_12,
                  sel_word.j.imm11, sel_word.j.imm10_1, 1'b0};

  // -------------------------------------------------------------------------
  // Target address
  // -------------------------------------------------------------------------
  always_comb begin
    // Default is the next sequential line
    base   = fetch_addr_i;
    offset = addr_t'(1) << LineAlign;
    if (|marked) begin
      base   = {fetch_addr_i[AddrWidth-1:LineAlign], sel_idx, {FetchAlign{1'b0}}};
      offset = is_jal[sel_idx] ? j_imm : b_imm;
    end
  end

  assign target          = base + offset;
  assign prefetch_addr_o = {target[AddrWidth-1:LineAlign], {LineAlign{1'b0}}};

endmodule

// File: hdl/l0_cache.sv
// -------------------------------------------------------------------------
// Four-line fully associative L0 instruction cache with prefetching.
// Hits answer in the same cycle. One refill is outstanding at a time.
// The fetch requester must hold its address until ready is seen.
// -------------------------------------------------------------------------

module l0_cache import l0_cache_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  enable_prefetch_i,

  input  addr_t                 fetch_addr_i,
  input  logic                  fetch_valid_i,
  output logic [FetchWidth-1:0] fetch_data_o,
  output logic                  fetch_ready_o,

  output addr_t                 out_req_addr_o,
  output logic                  out_req_prefetch_o,
  output logic                  out_req_valid_o,
  input  logic                  out_req_ready_i,

  input  logic                  out_rsp_valid_i,
  input  line_t                 out_rsp_data_i
);

  line_sel_t hit_line;
  logic      fetch_hit;
  logic      prefetch_hit;
  line_t     line_data;
  addr_t     prefetch_addr;
  logic      evict_req;
  line_sel_t victim;
  line_sel_t evict;
  logic      evict_prefetch;
  line_sel_t validate;

  assign fetch_ready_o = fetch_hit;

  l0_line_store i_line_store (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_addr_i     (fetch_addr_i),
    .prefetch_addr_i  (prefetch_addr),
    .evict_i          (evict),
    .evict_prefetch_i (evict_prefetch),
    .validate_i       (validate),
    .flush_i          (flush_i),
    .rsp_data_i       (out_rsp_data_i),
    .hit_line_o       (hit_line),
    .fetch_hit_o      (fetch_hit),
    .prefetch_hit_o   (prefetch_hit),
    .line_data_o      (line_data),
    .fetch_data_o     (fetch_data_o)
  );

  l0_victim_select i_victim_select (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .evict_req_i (evict_req),
    .hit_line_i  (hit_line),
    .victim_o    (victim)
  );

  l0_branch_predecode i_branch_predecode (
    .fetch_addr_i    (fetch_addr_i),
    .line_i          (line_data),
    .prefetch_addr_o (prefetch_addr)
  );

  l0_refill_ctrl i_refill_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_hit_i        (fetch_hit),
    .prefetch_hit_i     (prefetch_hit),
    .enable_prefetch_i  (enable_prefetch_i),
    .fetch_addr_i       (fetch_addr_i),
    .prefetch_addr_i    (prefetch_addr),
    .victim_i           (victim),
    .out_req_ready_i    (out_req_ready_i),
    .out_rsp_valid_i    (out_rsp_valid_i),
    .evict_req_o        (evict_req),
    .evict_o            (evict),
    .evict_prefetch_o   (evict_prefetch),
    .validate_o         (validate),
    .out_req_addr_o     (out_req_addr_o),
    .out_req_prefetch_o (out_req_prefetch_o),
    .out_req_valid_o    (out_req_valid_o)
  );

endmodule

// File: testbench/tb_clk_rst.sv
// -------------------------------------------------------------------------
// Free-running 8 ns clock and active-low reset for the testbench.
// Reset is held for 3 rising edges and released on a falling edge.
// -------------------------------------------------------------------------

module tb_clk_rst (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HalfPeriodNs = 4;
  localparam int unsigned ResetCycles  = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: testbench/tb_next_level.sv
// -------------------------------------------------------------------------
// Next memory level model. Ready is random, each accepted request gets its
// line back 3 cycles later. Word content is its address XOR a salt, except
// at a few addresses that hold branch and JAL instructions.
// -------------------------------------------------------------------------

module tb_next_level import l0_cache_pkg::*; (
  input  logic  clk_i,
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  input  logic  req_prefetch_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output line_t rsp_data_o,
  output logic  busy_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Low two bits clear, so a plain word never decodes as a branch or JAL
  localparam logic [31:0] Salt     = 32'h3C5A_96E0;
  localparam int unsigned RspDelay = 3;

  logic [AddrWidth:0] req_log [$];
  addr_t              rsp_addr;
  int unsigned        delay_q = 0;
  int unsigned        seed;

  function automatic logic [31:0] enc_branch(input int imm);
    logic [12:0] i;
    i = imm[12:0];
    return {i[12], i[10:5], 5'd2, 5'd1, 3'b000, i[4:1], i[11], OpcBranch};
  endfunction

  function automatic logic [31:0] enc_jal(input int imm);
    logic [20:0] i;
    i = imm[20:0];
    return {i[20], i[10:1], i[11], i[19:12], 5'd1, OpcJal};
  endfunction

  function automatic logic [FetchWidth-1:0] line_word(input addr_t addr);
    addr_t word_addr;
    word_addr = {addr[AddrWidth-1:FetchAlign], {FetchAlign{1'b0}}};
    case (word_addr)
      32'h0000_2008: return enc_branch(-64);
      32'h0000_3004: return enc_branch(256);
      32'h0000_4000: return enc_branch(-128);
      32'h0000_5004: return enc_jal(2048);
      32'h0000_500C: return enc_branch(-32);
      default:       return word_addr ^ Salt;
    endcase
  endfunction

  function automatic line_t line_content(input addr_t line_addr);
    line_t data;
    for (int w = 0; w < WordsPerLine; w++) begin
      data[w*FetchWidth +: FetchWidth] = line_word(line_addr + addr_t'(w * 4));
    end
    return data;
  endfunction

  // Accept and log requests, then count down to the response
  always @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_log.push_back({req_prefetch_i, req_addr_i});
      rsp_addr <= req_addr_i;
      delay_q  <= RspDelay;
    end else if (delay_q != 0) begin
      delay_q <= delay_q - 1;
    end
  end

  assign busy_o = (delay_q != 0);

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    seed        = 32'h96de8ae5;
    void'($urandom(seed));
    forever begin
      @(negedge clk_i);
      // Ready about three cycles in four
      req_ready_o = ($urandom_range(3) != 0);
      rsp_valid_o = (delay_q == 1);
      rsp_data_o  = (delay_q == 1) ? line_content(rsp_addr) : '0;
    end
  end

endmodule

// File: testbench/tb_l0_cache.sv
// -------------------------------------------------------------------------
// Table-driven testbench of the L0 instruction cache. Every test waits
// until the request port and the next level are idle, so each request
// seen by the next level belongs to exactly one test.
// -------------------------------------------------------------------------

module tb_l0_cache import l0_cache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumTests    = 23;
  localparam int unsigned CyclesEach  = 40;
  localparam int unsigned ClkPeriodNs = 8;
  localparam int unsigned LineBytes   = LineWidth / 8;
  // Targets are line aligned, so all ones marks a test without prefetch
  localparam addr_t       NoPrefetch  = '1;

  typedef struct packed {
    addr_t                 addr;
    logic                  pf_en;
    logic                  flush_first;
    logic                  demand;
    addr_t                 pf_addr;
    logic [FetchWidth-1:0] word;
  } test_t;

  test_t       tests [NumTests];
  int unsigned n_loaded   = 0;
  int unsigned n_checks   = 0;
  int unsigned n_mismatch = 0;
  int unsigned n_other    = 0;
  int unsigned cur_test   = 0;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  logic                  enable_prefetch;
  addr_t                 fetch_addr;
  logic                  fetch_valid;
  logic [FetchWidth-1:0] fetch_data;
  logic                  fetch_ready;
  addr_t                 req_addr;
  logic                  req_prefetch;
  logic                  req_valid;
  logic                  req_ready;
  logic                  rsp_valid;
  line_t                 rsp_data;
  logic                  busy;

  tb_clk_rst i_clk_rst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tb_next_level i_next_level (
    .clk_i          (clk),
    .req_valid_i    (req_valid),
    .req_addr_i     (req_addr),
    .req_prefetch_i (req_prefetch),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_data_o     (rsp_data),
    .busy_o         (busy)
  );

  l0_cache i_dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .flush_i            (flush),
    .enable_prefetch_i  (enable_prefetch),
    .fetch_addr_i       (fetch_addr),
    .fetch_valid_i      (fetch_valid),
    .fetch_data_o       (fetch_data),
    .fetch_ready_o      (fetch_ready),
    .out_req_addr_o     (req_addr),
    .out_req_prefetch_o (req_prefetch),
    .out_req_valid_o    (req_valid),
    .out_req_ready_i    (req_ready),
    .out_rsp_valid_i    (rsp_valid),
    .out_rsp_data_i     (rsp_data)
  );

  // -------------------------------------------------------------------------
  // Compare tasks
  // -------------------------------------------------------------------------
  task automatic check_word(input string name, input logic [FetchWidth-1:0] got,
                            input logic [FetchWidth-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH test %0d %s: got %h, expected %h", cur_test, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH test %0d %s: got %h, expected %h", cur_test, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH test %0d %s: got %h, expected %h", cur_test, name, got, exp);
    end
  endtask

  // Start address of the line that holds a byte address
  function automatic addr_t line_start(input addr_t addr);
    return (addr / LineBytes) * LineBytes;
  endfunction

  task automatic expect_request(input addr_t exp_addr, input logic exp_prefetch);
    logic [AddrWidth:0] req;
    if (i_next_level.req_log.size() == 0) begin
      n_other++;
      $display("ERROR test %0d: no request to %h reached the next level", cur_test, exp_addr);
    end else begin
      req = i_next_level.req_log.pop_front();
      check_addr("out_req_addr_o", req[AddrWidth-1:0], exp_addr);
      check_flag("out_req_prefetch_o", req[AddrWidth], exp_prefetch);
    end
  endtask

  // Demand refill first, then the prefetch, then nothing else
  task automatic check_requests(input test_t t);
    logic [AddrWidth:0] extra;
    if (t.demand) begin
      expect_request(line_start(t.addr), 1'b0);
    end
    if (t.pf_addr != NoPrefetch) begin
      expect_request(t.pf_addr, 1'b1);
    end
    while (i_next_level.req_log.size() != 0) begin
      extra = i_next_level.req_log.pop_front();
      n_other++;
      $display("ERROR test %0d: unexpected request to %h with prefetch flag %b",
               cur_test, extra[AddrWidth-1:0], extra[AddrWidth]);
    end
  endtask

  // -------------------------------------------------------------------------
  // Test table
  // -------------------------------------------------------------------------
  task automatic add_test(input addr_t addr, input logic pf_en, input logic flush_first,
                          input logic demand, input addr_t pf_addr);
    tests[n_loaded] = '{addr, pf_en, flush_first, demand, pf_addr,
                        i_next_level.line_word(addr)};
    n_loaded++;
  endtask

  task automatic load_tests();
    // Cold miss, hit, next-line prefetch
    add_test(32'h0000_1000, 1'b0, 1'b0, 1'b1, NoPrefetch);
    add_test(32'h0000_1008, 1'b0, 1'b0, 1'b0, NoPrefetch);
    add_test(32'h0000_100C, 1'b1, 1'b0, 1'b0, 32'h0000_1010);
    add_test(32'h0000_1014, 1'b0, 1'b0, 1'b0, NoPrefetch);
    // Backward branch, forward branch, backward branch before the word, JAL
    add_test(32'h0000_2000, 1'b1, 1'b0, 1'b1, 32'h0000_1FC0);
    add_test(32'h0000_3004, 1'b1, 1'b0, 1'b1, 32'h0000_3010);
    add_test(32'h0000_4008, 1'b1, 1'b0, 1'b1, 32'h0000_4010);
    add_test(32'h0000_5000, 1'b1, 1'b0, 1'b1, 32'h0000_5800);
    // Flush, then round-robin over five lines
    add_test(32'h0000_5000, 1'b0, 1'b1, 1'b1, NoPrefetch);
    add_test(32'h0000_6000, 1'b0, 1'b1, 1'b1, NoPrefetch);
    add_test(32'h0000_6010, 1'b0, 1'b0, 1'b1, NoPrefetch);
    add_test(32'h0000_6020, 1'b0, 1'b0, 1'b1, NoPrefetch);
    add_test(32'h0000_6030, 1'b0, 1'b0, 1'b1, NoPrefetch);
    add_test(32'h0000_6040, 1'b0, 1'b0, 1'b1, NoPrefetch);
    add_test(32'h0000_6010, 1'b0, 1'b0, 1'b0, NoPrefetch);
    add_test(32'h0000_6020, 1'b0, 1'b0, 1'b0, NoPrefetch);
    add_test(32'h0000_6030, 1'b0, 1'b0, 1'b0, NoPrefetch);
    add_test(32'h0000_6040, 1'b0, 1'b0, 1'b0, NoPrefetch);
    add_test(32'h0000_6000, 1'b0, 1'b0, 1'b1, NoPrefetch);
    // Two evictions move the counter onto the line of 0x6040, whose prefetch skips it
    add_test(32'h0000_7000, 1'b1, 1'b0, 1'b1, 32'h0000_7010);
    add_test(32'h0000_6040, 1'b1, 1'b0, 1'b0, 32'h0000_6050);
    add_test(32'h0000_6048, 1'b0, 1'b0, 1'b0, NoPrefetch);
    add_test(32'h0000_6050, 1'b0, 1'b0, 1'b0, NoPrefetch);
  endtask

  task automatic run_test(input test_t t);
    if (t.flush_first) begin
      fetch_valid = 1'b0;
      flush       = 1'b1;
      @(negedge clk);
      flush       = 1'b0;
    end
    fetch_addr      = t.addr;
    fetch_valid     = 1'b1;
    enable_prefetch = t.pf_en;
    do begin
      @(negedge clk);
    end while (fetch_ready !== 1'b1);
    check_word("fetch_data_o", fetch_data, t.word);
    // Leave room for a prefetch to start, then wait for an idle port
    repeat (2) @(negedge clk);
    while (req_valid || busy) begin
      @(negedge clk);
    end
    check_requests(t);
  endtask

  initial begin
    flush           = 1'b0;
    enable_prefetch = 1'b0;
    fetch_addr      = '0;
    fetch_valid     = 1'b0;
    load_tests();
    wait (rst_n === 1'b1);
    @(negedge clk);
    for (int i = 0; i < NumTests; i++) begin
      cur_test = i;
      run_test(tests[i]);
    end
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NumTests * CyclesEach * ClkPeriodNs);
    $display("ERROR: timeout, test %0d did not complete within the cycle limit", cur_test);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: build.f
hdl/l0_cache_pkg.sv
hdl/l0_line_store.sv
hdl/l0_victim_select.sv
hdl/l0_refill_ctrl.sv
hdl/l0_branch_predecode.sv
hdl/l0_cache.sv
testbench/tb_clk_rst.sv
testbench/tb_next_level.sv
testbench/tb_l0_cache.sv

// File: Bender.yml
package:
  name: l0_cache

sources:
  - files:
      - hdl/l0_cache_pkg.sv
      - hdl/l0_line_store.sv
      - hdl/l0_victim_select.sv
      - hdl/l0_refill_ctrl.sv
      - hdl/l0_branch_predecode.sv
      - hdl/l0_cache.sv
  - target: test
    files:
      - testbench/tb_clk_rst.sv
      - testbench/tb_next_level.sv
      - testbench/tb_l0_cache.sv
